// ==== design/armPkg.sv ====
// armPkg: shared word types, instruction views and control encodings for the ARM pipeline
package armPkg;

  typedef logic [31:0] Word;
  typedef logic [3:0]  RegAddr;

  // NZCV order, N in bit 3
  typedef logic [3:0] Flags;

  typedef logic [1:0] AluCtl;
  localparam AluCtl aluAdd = 2'd0;
  localparam AluCtl aluSub = 2'd1;
  localparam AluCtl aluAnd = 2'd2;
  localparam AluCtl aluOrr = 2'd3;

  typedef logic [1:0] ImmSrc;
  localparam ImmSrc immDp8   = 2'd0;
  localparam ImmSrc immMem12 = 2'd1;
  localparam ImmSrc immBr24  = 2'd2;

  typedef logic [1:0] FwdSel;
  localparam FwdSel fwdNone = 2'd0;
  localparam FwdSel fwdWb   = 2'd1;
  localparam FwdSel fwdMem  = 2'd2;

  // instruction class in bits 27:26
  localparam logic [1:0] opDp  = 2'b00;
  localparam logic [1:0] opMem = 2'b01;
  localparam logic [1:0] opBr  = 2'b10;

  // data processing cmd field
  localparam logic [3:0] cmdAnd = 4'b0000;
  localparam logic [3:0] cmdSub = 4'b0010;
  localparam logic [3:0] cmdAdd = 4'b0100;
  localparam logic [3:0] cmdOrr = 4'b1100;

  localparam Word pcStep = 32'd4;

  // one instruction word seen as data processing, memory or branch
  typedef union packed {
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  op;
      logic        i;
      logic [3:0]  cmd;
      logic        s;
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] src2;
    } dp;
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  op;
      logic        iBit;
      logic        p;
      logic        u;
      logic        b;
      logic        w;
      logic        l;
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] imm12;
    } mem;
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  op;
      logic [1:0]  funct;
      logic [23:0] imm24;
    } br;
  } InstrWord;

endpackage

// ==== design/armRegFile.sv ====
// armRegFile: R0-R14 storage with two read ports, falling-edge write, R15 read as PC+8
`timescale 1ns/1ps

module armRegFile (
  input  logic          clk,
  input  logic          we,
  input  armPkg::RegAddr ra1,
  input  armPkg::RegAddr ra2,
  input  armPkg::RegAddr wa,
  input  armPkg::Word    wd,
  input  armPkg::Word    r15,
  output armPkg::Word    rd1,
  output armPkg::Word    rd2
);

  armPkg::Word regs [0:14];

  // write on the falling edge so decode sees the writeback value in the same cycle
  always_ff @(negedge clk) begin
    if (we) begin
      regs[wa] <= wd;
    end
  end

  assign rd1 = (ra1 == 4'd15) ? r15 : regs[ra1];
  assign rd2 = (ra2 == 4'd15) ? r15 : regs[ra2];

  // the PC is never a destination in this subset
  assert property (@(posedge clk) we |-> (wa != 4'd15))
    else $error("register file write to R15");

endmodule

// ==== design/armAlu.sv ====
// armAlu: add, subtract, and, or with NZCV flag generation
`timescale 1ns/1ps

module armAlu (
  input  armPkg::Word   a,
  input  armPkg::Word   b,
  input  armPkg::AluCtl ctl,
  output armPkg::Word   y,
  output armPkg::Flags  flags
);

  logic        isSub;
  logic        isArith;
  armPkg::Word bOp;
  logic [32:0] sum;
  logic        carry;
  logic        overflow;

  assign isSub   = (ctl == armPkg::aluSub);
  assign isArith = (ctl == armPkg::aluAdd) || isSub;

  // subtract as a + ~b + 1, so C is the inverted borrow
  assign bOp = isSub ? ~b : b;
  assign sum = {1'b0, a} + {1'b0, bOp} + {32'd0, isSub};

  always_comb begin
    case (ctl)
      armPkg::aluAnd: y = a & b;
      armPkg::aluOrr: y = a | b;
      default:        y = sum[31:0];
    endcase
  end

  // overflow when both operands agree in sign and the result does not
  assign overflow = isArith && (a[31] == bOp[31]) && (sum[31] != a[31]);
  assign carry    = isArith && sum[32];

  assign flags = {y[31], (y == 32'd0), carry, overflow};

endmodule

// ==== design/armController.sv ====
// armController: instruction decode, condition check and the NZCV flags register
`timescale 1ns/1ps

module armController (
  input  logic             clk,
  input  logic             rst,
  input  armPkg::InstrWord instrD,
  input  armPkg::Flags     aluFlagsE,
  input  logic             flushE,
  output logic             regWriteD,
  output logic             memWriteD,
  output logic             memtoRegD,
  output logic             branchD,
  output logic             aluSrcD,
  output logic             flagWriteD,
  output armPkg::AluCtl    aluCtlD,
  output armPkg::ImmSrc    immSrcD,
  output logic [1:0]       regSrcD,
  input  logic [3:0]       condE,
  input  logic             flagWriteE,
  input  logic             branchE,
  output logic             condExE,
  output logic             branchTakenE
);

  armPkg::Flags flagsReg;
  logic         n, z, c, v;

  always_comb begin
    regWriteD  = 1'b0;
    memWriteD  = 1'b0;
    memtoRegD  = 1'b0;
    branchD    = 1'b0;
    aluSrcD    = 1'b1;
    flagWriteD = 1'b0;
    aluCtlD    = armPkg::aluAdd;
    immSrcD    = armPkg::immDp8;
    regSrcD    = 2'b00;
    case (instrD.dp.op)
      armPkg::opDp: begin
        regWriteD  = 1'b1;
        aluSrcD    = instrD.dp.i;
        flagWriteD = instrD.dp.s;
        case (instrD.dp.cmd)
          armPkg::cmdAdd: aluCtlD = armPkg::aluAdd;
          armPkg::cmdSub: aluCtlD = armPkg::aluSub;
          armPkg::cmdAnd: aluCtlD = armPkg::aluAnd;
          armPkg::cmdOrr: aluCtlD = armPkg::aluOrr;
          default: begin
            // unsupported opcode becomes a no-op
            regWriteD  = 1'b0;
            flagWriteD = 1'b0;
          end
        endcase
      end
      armPkg::opMem: begin
        immSrcD = armPkg::immMem12;
        if (instrD.mem.l) begin
          regWriteD = 1'b1;
          memtoRegD = 1'b1;
        end else begin
          memWriteD = 1'b1;
          // store data comes from rd on the second read port
          regSrcD[1] = 1'b1;
        end
      end
      armPkg::opBr: begin
        // target is PC+8 plus the shifted offset, through the ALU
        branchD    = (instrD.br.funct == 2'b10);
        immSrcD    = armPkg::immBr24;
        regSrcD[0] = 1'b1;
      end
      default: ;
    endcase
  end

  assign {n, z, c, v} = flagsReg;

  always_comb begin
    case (condE)
      4'b0000: condExE = z;
      4'b0001: condExE = !z;
      4'b0010: condExE = c;
      4'b0011: condExE = !c;
      4'b0100: condExE = n;
      4'b0101: condExE = !n;
      4'b0110: condExE = v;
      4'b0111: condExE = !v;
      4'b1000: condExE = c && !z;
      4'b1001: condExE = !c || z;
      4'b1010: condExE = (n == v);
      4'b1011: condExE = (n != v);
      4'b1100: condExE = !z && (n == v);
      4'b1101: condExE = z || (n != v);
      default: condExE = 1'b1;
    endcase
  end

  assign branchTakenE = branchE && condExE;

  // flags change only when the S instruction itself passes its condition
  always_ff @(posedge clk) begin
    if (rst) begin
      flagsReg <= '0;
    end else if (flagWriteE && condExE) begin
      flagsReg <= aluFlagsE;
    end
  end

  assert property (@(posedge clk) disable iff (rst) !(branchD && memWriteD))
    else $error("decode raised both branch and store");

  // a flushed slot reaches execute with no branch and no flag write
  assert property (@(posedge clk) disable iff (rst) flushE |=> (!branchE && !flagWriteE))
    else $error("squashed instruction reached execute");

endmodule

// ==== design/armHazard.sv ====
// armHazard: forwarding selects, load-use stall and branch flush
`timescale 1ns/1ps

module armHazard (
  input  logic          match1EM,
  input  logic          match1EW,
  input  logic          match2EM,
  input  logic          match2EW,
  input  logic          match12DE,
  input  logic          regWriteM,
  input  logic          regWriteW,
  input  logic          memtoRegE,
  input  logic          branchTakenE,
  output logic          stallF,
  output logic          stallD,
  output logic          flushD,
  output logic          flushE,
  output armPkg::FwdSel fwdAE,
  output armPkg::FwdSel fwdBE
);

  logic ldrStall;

  // the memory stage holds the younger result, so it wins
  always_comb begin
    if (match1EM && regWriteM) fwdAE = armPkg::fwdMem;
    else if (match1EW && regWriteW) fwdAE = armPkg::fwdWb;
    else fwdAE = armPkg::fwdNone;

    if (match2EM && regWriteM) fwdBE = armPkg::fwdMem;
    else if (match2EW && regWriteW) fwdBE = armPkg::fwdWb;
    else fwdBE = armPkg::fwdNone;
  end

  // load in E feeding the instruction in D
  assign ldrStall = match12DE && memtoRegE;

  assign stallF = ldrStall;
  assign stallD = ldrStall;
  assign flushD = branchTakenE;
  assign flushE = ldrStall || branchTakenE;

endmodule

// ==== design/armDatapath.sv ====
// armDatapath: PC, pipeline registers, operand selection and forwarding for the ARM pipeline
`timescale 1ns/1ps

module armDatapath (
  input  logic             clk,
  input  logic             rst,
  input  armPkg::Word      instrF,
  input  armPkg::Word      readDataM,
  input  logic             regWriteD, memWriteD, memtoRegD, branchD, aluSrcD, flagWriteD,
  input  armPkg::AluCtl    aluCtlD,
  input  armPkg::ImmSrc    immSrcD,
  input  logic [1:0]       regSrcD,
  input  logic             stallF, stallD, flushD, flushE,
  input  armPkg::FwdSel    fwdAE, fwdBE,
  input  logic             condExE, branchTakenE,
  output armPkg::InstrWord instrD,
  output armPkg::Word      pcF, aluOutM, writeDataM,
  output logic             memWriteM,
  output logic [3:0]       condE,
  output logic             flagWriteE, branchE,
  output armPkg::Flags     aluFlagsE,
  output logic             memtoRegE, regWriteM, regWriteW,
  output logic             match1EM, match1EW, match2EM, match2EW, match12DE
);

  armPkg::Word    pcNextF, pcPlus4F, pcPlus8D;
  logic           validD;
  armPkg::RegAddr ra1D, ra2D, waD;
  armPkg::Word    rd1D, rd2D, extImmD;

  logic           regWriteE, memWriteE, aluSrcE;
  armPkg::AluCtl  aluCtlE;
  armPkg::Word    rd1E, rd2E, extImmE;
  armPkg::RegAddr ra1E, ra2E, waE;
  armPkg::Word    srcAE, srcBE, writeDataE, aluResultE;

  logic           memtoRegM, memtoRegW;
  armPkg::RegAddr waM, waW;
  armPkg::Word    aluOutW, readDataW, resultW;

  function automatic armPkg::Word fwdMux(input armPkg::FwdSel sel, input armPkg::Word regVal,
                                         input armPkg::Word wbVal, input armPkg::Word memVal);
    case (sel)
      armPkg::fwdWb:  fwdMux = wbVal;
      armPkg::fwdMem: fwdMux = memVal;
      default:        fwdMux = regVal;
    endcase
  endfunction

  // fetch
  assign pcPlus4F = pcF + armPkg::pcStep;
  assign pcNextF  = branchTakenE ? aluResultE : pcPlus4F;

  always_ff @(posedge clk) begin
    if (rst) begin
      pcF <= '0;
    end else if (!stallF) begin
      pcF <= pcNextF;
    end
  end

  // decode
  always_ff @(posedge clk) begin
    if (rst || flushD) begin
      validD <= 1'b0;
    end else if (!stallD) begin
      validD <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallD) begin
      instrD <= instrF;
    end
  end

  // fetch is one word ahead of decode, so PC+4 in F is PC+8 of D
  assign pcPlus8D = pcPlus4F;
  assign ra1D     = regSrcD[0] ? 4'd15 : instrD.mem.rn;
  assign ra2D     = regSrcD[1] ? instrD.mem.rd : instrD.mem.imm12[3:0];
  assign waD      = instrD.mem.rd;

  always_comb begin
    case (immSrcD)
      armPkg::immDp8:   extImmD = {24'd0, instrD.mem.imm12[7:0]};
      armPkg::immMem12: extImmD = {20'd0, instrD.mem.imm12};
      armPkg::immBr24:  extImmD = {{6{instrD.br.imm24[23]}}, instrD.br.imm24, 2'b00};
      default:          extImmD = '0;
    endcase
  end

  armRegFile rf (
    .clk(clk), .we(regWriteW), .ra1(ra1D), .ra2(ra2D), .wa(waW),
    .wd(resultW), .r15(pcPlus8D), .rd1(rd1D), .rd2(rd2D)
  );

  // execute, bubble on flush or an empty decode slot
  always_ff @(posedge clk) begin
    if (rst || flushE || !validD) begin
      regWriteE  <= 1'b0;
      memWriteE  <= 1'b0;
      memtoRegE  <= 1'b0;
      branchE    <= 1'b0;
      flagWriteE <= 1'b0;
      aluSrcE    <= 1'b0;
      aluCtlE    <= armPkg::aluAdd;
      condE      <= 4'b1110;
    end else begin
      regWriteE  <= regWriteD;
      memWriteE  <= memWriteD;
      memtoRegE  <= memtoRegD;
      branchE    <= branchD;
      flagWriteE <= flagWriteD;
      aluSrcE    <= aluSrcD;
      aluCtlE    <= aluCtlD;
      condE      <= instrD.mem.cond;
    end
  end

  always_ff @(posedge clk) begin
    rd1E    <= rd1D;
    rd2E    <= rd2D;
    extImmE <= extImmD;
    ra1E    <= ra1D;
    ra2E    <= ra2D;
    waE     <= waD;
  end

  assign srcAE      = fwdMux(fwdAE, rd1E, resultW, aluOutM);
  assign writeDataE = fwdMux(fwdBE, rd2E, resultW, aluOutM);
  assign srcBE      = aluSrcE ? extImmE : writeDataE;

  armAlu alu (.a(srcAE), .b(srcBE), .ctl(aluCtlE), .y(aluResultE), .flags(aluFlagsE));

  // memory, writes dropped when the condition fails
  always_ff @(posedge clk) begin
    if (rst) begin
      regWriteM <= 1'b0;
      memWriteM <= 1'b0;
      memtoRegM <= 1'b0;
    end else begin
      regWriteM <= regWriteE && condExE;
      memWriteM <= memWriteE && condExE;
      memtoRegM <= memtoRegE;
    end
  end

  always_ff @(posedge clk) begin
    aluOutM    <= aluResultE;
    writeDataM <= writeDataE;
    waM        <= waE;
  end

  // writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      regWriteW <= 1'b0;
      memtoRegW <= 1'b0;
    end else begin
      regWriteW <= regWriteM;
      memtoRegW <= memtoRegM;
    end
  end

  always_ff @(posedge clk) begin
    aluOutW   <= aluOutM;
    readDataW <= readDataM;
    waW       <= waM;
  end

  assign resultW = memtoRegW ? readDataW : aluOutW;

  // register matches for the hazard unit
  assign match1EM  = (ra1E == waM);
  assign match1EW  = (ra1E == waW);
  assign match2EM  = (ra2E == waM);
  assign match2EW  = (ra2E == waW);
  assign match12DE = (ra1D == waE) || (ra2D == waE);

endmodule

// ==== design/armPipeline.sv ====
// armPipeline: five-stage ARM subset core joining datapath, controller and hazard unit
`timescale 1ns/1ps

module armPipeline (
  input  logic        clk,
  input  logic        rst,
  output armPkg::Word pcF,
  input  armPkg::Word instrF,
  output armPkg::Word aluOutM,
  output armPkg::Word writeDataM,
  output logic        memWriteM,
  input  armPkg::Word readDataM
);

  armPkg::InstrWord instrD;
  logic             regWriteD, memWriteD, memtoRegD, branchD, aluSrcD, flagWriteD;
  armPkg::AluCtl    aluCtlD;
  armPkg::ImmSrc    immSrcD;
  logic [1:0]       regSrcD;
  logic [3:0]       condE;
  logic             flagWriteE, branchE, condExE, branchTakenE;
  armPkg::Flags     aluFlagsE;
  logic             memtoRegE, regWriteM, regWriteW;
  logic             match1EM, match1EW, match2EM, match2EW, match12DE;
  logic             stallF, stallD, flushD, flushE;
  armPkg::FwdSel    fwdAE, fwdBE;

  armController ctrl (
    .clk(clk), .rst(rst), .instrD(instrD), .aluFlagsE(aluFlagsE), .flushE(flushE),
    .regWriteD(regWriteD), .memWriteD(memWriteD), .memtoRegD(memtoRegD),
    .branchD(branchD), .aluSrcD(aluSrcD), .flagWriteD(flagWriteD),
    .aluCtlD(aluCtlD), .immSrcD(immSrcD), .regSrcD(regSrcD),
    .condE(condE), .flagWriteE(flagWriteE), .branchE(branchE),
    .condExE(condExE), .branchTakenE(branchTakenE)
  );

  armDatapath dp (
    .clk(clk), .rst(rst), .instrF(instrF), .readDataM(readDataM),
    .regWriteD(regWriteD), .memWriteD(memWriteD), .memtoRegD(memtoRegD),
    .branchD(branchD), .aluSrcD(aluSrcD), .flagWriteD(flagWriteD),
    .aluCtlD(aluCtlD), .immSrcD(immSrcD), .regSrcD(regSrcD),
    .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE),
    .fwdAE(fwdAE), .fwdBE(fwdBE), .condExE(condExE), .branchTakenE(branchTakenE),
    .instrD(instrD), .pcF(pcF), .aluOutM(aluOutM), .writeDataM(writeDataM),
    .memWriteM(memWriteM), .condE(condE), .flagWriteE(flagWriteE), .branchE(branchE),
    .aluFlagsE(aluFlagsE), .memtoRegE(memtoRegE), .regWriteM(regWriteM),
    .regWriteW(regWriteW), .match1EM(match1EM), .match1EW(match1EW),
    .match2EM(match2EM), .match2EW(match2EW), .match12DE(match12DE)
  );

  armHazard hz (
    .match1EM(match1EM), .match1EW(match1EW), .match2EM(match2EM), .match2EW(match2EW),
    .match12DE(match12DE), .regWriteM(regWriteM), .regWriteW(regWriteW),
    .memtoRegE(memtoRegE), .branchTakenE(branchTakenE),
    .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE),
    .fwdAE(fwdAE), .fwdBE(fwdBE)
  );

endmodule

// ==== testbench/armPipelineTb.sv ====
// armPipelineTb: testbench that runs a test program on the ARM pipeline and checks every store
`timescale 1ns/1ps

module armPipelineTb;

  logic        clk;
  logic        rst;
  armPkg::Word instrF;
  armPkg::Word readDataM;
  armPkg::Word pcF;
  armPkg::Word aluOutM;
  armPkg::Word writeDataM;
  logic        memWriteM;

  // word-addressed memories, 1 KB each
  armPkg::Word imem [0:255];
  armPkg::Word dmem [0:255];

  // expected stores, oldest first
  armPkg::Word expAddr [$];
  armPkg::Word expData [$];

  int progWords;
  int cycles;
  int cycleLimit;

  armPipeline UUT (
    .clk(clk),
    .rst(rst),
    .pcF(pcF),
    .instrF(instrF),
    .aluOutM(aluOutM),
    .writeDataM(writeDataM),
    .memWriteM(memWriteM),
    .readDataM(readDataM)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // fill both memories, then apply the program, presets and expected stores
  task automatic loadCases();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  tag;
    armPkg::Word addr;
    armPkg::Word data;
    for (int i = 0; i < 256; i++) begin
      // unsupported data processing opcode, decodes as a no-op
      imem[i] = 32'he1a00000 | (armPkg::Word'(i) << 2);
      dmem[i] = 32'hda7a0000 | (armPkg::Word'(i) << 2);
    end
    fd = $fopen("testbench/programCases.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/programCases.txt");
      $display("ERRORS FOUND");
      $fatal(1, "missing case file");
    end
    while ($fgets(line, fd) != 0) begin
      tag = line.getc(0);
      if (line.len() > 1 && tag != "#") begin
        n = $sscanf(line.substr(1, line.len() - 1), "%h %h", addr, data);
        if (n != 2) begin
          $display("malformed line in case file: %s", line);
          $display("ERRORS FOUND");
          $fatal(1, "bad case file");
        end
        case (tag)
          "I": begin
            imem[addr[9:2]] = data;
            progWords++;
          end
          "D": dmem[addr[9:2]] = data;
          "S": begin
            expAddr.push_back(addr);
            expData.push_back(data);
          end
          default: begin
            $display("unknown record type in case file: %s", line);
            $display("ERRORS FOUND");
            $fatal(1, "bad case file");
          end
        endcase
      end
    end
    $fclose(fd);
    if (progWords == 0 || expAddr.size() == 0) begin
      $display("case file holds no program or no expected stores");
      $display("ERRORS FOUND");
      $fatal(1, "empty case file");
    end
  endtask

  // compare one store against the head of the expected queue
  task automatic checkStore(input armPkg::Word addr, input armPkg::Word data);
    if (expAddr.size() == 0) begin
      $display("unexpected store of %h to address %h at %0t ns", data, addr, $time);
      $display("ERRORS FOUND");
      $fatal(1, "unexpected store");
    end else if (addr !== expAddr[0] || data !== expData[0]) begin
      $display("Fail at %0t ns: store %h to address %h, expected %h to address %h",
               $time, data, addr, expData[0], expAddr[0]);
      $display("ERRORS FOUND");
      $fatal(1, "store mismatch");
    end else begin
      void'(expAddr.pop_front());
      void'(expData.pop_front());
    end
  endtask

  // stores are checked and committed on the rising edge
  always @(posedge clk) begin
    cycles++;
    if (memWriteM) begin
      if (rst) begin
        $display("store strobe raised during reset at %0t ns", $time);
        $display("ERRORS FOUND");
        $fatal(1, "store in reset");
      end else begin
        checkStore(aluOutM, writeDataM);
        dmem[aluOutM[9:2]] = writeDataM;
      end
    end
  end

  // memory read ports, driven on the falling edge
  initial begin
    instrF    = '0;
    readDataM = '0;
    forever begin
      @(negedge clk);
      instrF    = imem[pcF[9:2]];
      readDataM = dmem[aluOutM[9:2]];
    end
  end

  initial begin
    rst        = 1'b1;
    progWords  = 0;
    cycles     = 0;
    loadCases();
    cycleLimit = 10 * progWords + 100;
    repeat (16) @(negedge clk);
    rst = 1'b0;

    // run until every expected store has been seen
    while (expAddr.size() != 0 && cycles < cycleLimit) begin
      @(negedge clk);
    end

    if (expAddr.size() == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("timeout after %0d cycles with %0d stores still pending",
               cycles, expAddr.size());
      $display("ERRORS FOUND");
      $fatal(1, "timeout");
    end
  end

endmodule

// ==== testbench/programCases.txt ====
# program image, preset data and expected stores for the ARM pipeline testbench
# columns: I addr word = instruction, D addr word = data preset, S addr data = expected store
# forwarding chain through M and W
I 00000000 e2000000
I 00000004 e280105a
I 00000008 e281203f
I 0000000c e0423001
I 00000010 e0034002
I 00000014 e1845001
I 00000018 e5805040
I 0000001c e5803044
I 00000020 e5804048
# load followed by a dependent instruction
I 00000024 e5906080
I 00000028 e2867077
I 0000002c e580704c
I 00000030 e5908084
I 00000034 e5808050
# flag setting subtract and conditional stores
I 00000038 e0519002
I 0000003c 05809054
I 00000040 15809058
I 00000044 4580105c
I 00000048 a5802060
I 0000004c e253a03f
I 00000050 05803064
I 00000054 15803068
I 00000058 4580306c
I 0000005c a580a070
# branches, R15 read and final self loop
I 00000060 1a000002
I 00000064 e5801074
I 00000068 ea000001
I 0000006c e5802078
I 00000070 e580307c
I 00000074 e28fb010
I 00000078 e580b094
I 0000007c eafffffe
# data presets
D 00000080 12345600
D 00000084 cafef00d
# expected stores in program order
S 00000040 0000005b
S 00000044 0000003f
S 00000048 00000019
S 0000004c 12345677
S 00000050 cafef00d
S 00000058 ffffffc1
S 0000005c 0000005a
S 00000064 0000003f
S 00000070 00000000
S 00000074 0000005a
S 00000094 0000008c

// ==== src.f ====
design/armPkg.sv
design/armRegFile.sv
design/armAlu.sv
design/armController.sv
design/armHazard.sv
design/armDatapath.sv
design/armPipeline.sv
testbench/armPipelineTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module armPipelineTb -f src.f -o armPipelineSim &&
  ./obj_dir/armPipelineSim | tee /dev/stderr | grep -q "^NO ERRORS$" &&
  echo "PASS" ||
  { echo "FAIL"; exit 1; }
